/* include/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath widths
`define XLEN       32
`define REG_AW     5

// instruction buffer
`define FIFO_DEPTH 8
`define RESET_PC   32'hbfc00000

// primary opcodes
`define OP_SPECIAL 6'h00
`define OP_ADDIU   6'h09
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f

// funct codes under SPECIAL
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_SLT     6'h2a

`endif

/* hdl/core_pkg.sv */
`default_nettype none
`include "core_defines.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`XLEN-1:0]   inst_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;

    // one code per ALU function, NOP for anything unsupported
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI,
        ALU_NOP
    } alu_op_e;

endpackage

`default_nettype wire

/* hdl/inst_fifo.sv */
`default_nettype none
`include "core_defines.svh"

module inst_fifo
    import core_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         wr1_en_i,
    input  logic                         wr2_en_i,
    input  inst_t                        wr1_data_i,
    input  inst_t                        wr2_data_i,
    input  logic                         pop1_i,
    input  logic                         pop2_i,
    output inst_t                        head_inst_o,
    output word_t                        head_pc_o,
    output inst_t                        next_inst_o,
    output word_t                        next_pc_o,
    output logic [$clog2(`FIFO_DEPTH):0] count_o,
    output logic                         room_o
);
    localparam int PW = $clog2(`FIFO_DEPTH);
    localparam int CW = PW + 1;

    inst_t         inst_mem [`FIFO_DEPTH];
    word_t         pc_mem   [`FIFO_DEPTH];
    logic [PW-1:0] rd_ptr, wr_ptr;
    word_t         fetch_pc;
    logic          wr2, pop2;
    logic [1:0]    n_push, n_pop;

    // second slot only counts behind the first
    assign wr2    = wr1_en_i & wr2_en_i;
    assign pop2   = pop1_i & pop2_i;
    assign n_push = {1'b0, wr1_en_i} + {1'b0, wr2};
    assign n_pop  = {1'b0, pop1_i} + {1'b0, pop2};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count_o  <= '0;
            fetch_pc <= `RESET_PC;
        end else begin
            rd_ptr   <= rd_ptr + PW'(n_pop);
            wr_ptr   <= wr_ptr + PW'(n_push);
            count_o  <= count_o + CW'(n_push) - CW'(n_pop);
            fetch_pc <= fetch_pc + word_t'({n_push, 2'b00});
        end
    end

    // entries carry the fetch pc as a tag
    always_ff @(posedge clk) begin
        if (wr1_en_i) begin
            inst_mem[wr_ptr] <= wr1_data_i;
            pc_mem[wr_ptr]   <= fetch_pc;
        end
        if (wr2) begin
            inst_mem[wr_ptr + 1'b1] <= wr2_data_i;
            pc_mem[wr_ptr + 1'b1]   <= fetch_pc + word_t'(4);
        end
    end

    assign head_inst_o = inst_mem[rd_ptr];
    assign head_pc_o   = pc_mem[rd_ptr];
    assign next_inst_o = inst_mem[rd_ptr + 1'b1];
    assign next_pc_o   = pc_mem[rd_ptr + 1'b1];

    // a full fetch beat needs two free slots
    assign room_o = (CW'(`FIFO_DEPTH) - count_o) >= CW'(2);

endmodule

`default_nettype wire

/* hdl/decoder.sv */
`default_nettype none
`include "core_defines.svh"

module decoder
    import core_pkg::*;
(
    input  inst_t     inst_i,
    output reg_addr_t rs_o,
    output reg_addr_t rt_o,
    output reg_addr_t waddr_o,
    output word_t     imm_o,
    output alu_op_e   alu_op_o,
    output logic      use_imm_o,
    output logic      reg_wen_o
);
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rd;
    logic       sign_ext;

    assign opcode = inst_i[31:26];
    assign funct  = inst_i[5:0];
    assign rs_o   = inst_i[25:21];
    assign rt_o   = inst_i[20:16];
    assign rd     = inst_i[15:11];

    // addiu is the only signed immediate here
    assign sign_ext  = (opcode == `OP_ADDIU);
    assign use_imm_o = (opcode != `OP_SPECIAL);
    assign imm_o     = sign_ext ? word_t'($signed(inst_i[15:0])) : word_t'(inst_i[15:0]);

    // R-type writes rd, I-type writes rt
    assign waddr_o = (opcode == `OP_SPECIAL) ? rd : rt_o;

    always_comb begin
        alu_op_o = ALU_NOP;
        case (opcode)
            `OP_SPECIAL: begin
                case (funct)
                    `FN_ADDU: alu_op_o = ALU_ADD;
                    `FN_SUBU: alu_op_o = ALU_SUB;
                    `FN_AND:  alu_op_o = ALU_AND;
                    `FN_OR:   alu_op_o = ALU_OR;
                    `FN_XOR:  alu_op_o = ALU_XOR;
                    `FN_SLT:  alu_op_o = ALU_SLT;
                    default:  alu_op_o = ALU_NOP;
                endcase
            end
            `OP_ADDIU: alu_op_o = ALU_ADD;
            `OP_ANDI:  alu_op_o = ALU_AND;
            `OP_ORI:   alu_op_o = ALU_OR;
            `OP_LUI:   alu_op_o = ALU_LUI;
            default:   alu_op_o = ALU_NOP;
        endcase
    end

    // unknown encodings and writes to $0 retire silently
    assign reg_wen_o = (alu_op_o != ALU_NOP) && (waddr_o != '0);

endmodule

`default_nettype wire

/* hdl/issue_ctrl.sv */
`default_nettype none
`include "core_defines.svh"

module issue_ctrl
    import core_pkg::*;
(
    input  logic [$clog2(`FIFO_DEPTH):0] count_i,
    input  logic                         master_wen_i,
    input  reg_addr_t                    master_waddr_i,
    input  reg_addr_t                    slave_rs_i,
    input  reg_addr_t                    slave_rt_i,
    output logic                         master_issue_o,
    output logic                         slave_issue_o
);
    localparam int CW = $clog2(`FIFO_DEPTH) + 1;

    logic pair_ready;
    logic master_writes;
    logic no_raw;

    assign master_issue_o = (count_i != '0);
    assign pair_ready     = (count_i >= CW'(2));
    assign master_writes  = master_wen_i && (master_waddr_i != '0);

    // slave may not read what the master is producing this cycle
    assign no_raw = (master_waddr_i != slave_rs_i) && (master_waddr_i != slave_rt_i);

    assign slave_issue_o = master_issue_o
                        && pair_ready
                        && master_writes
                        && no_raw;

endmodule

`default_nettype wire

/* hdl/regfile.sv */
`default_nettype none
`include "core_defines.svh"

module regfile
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  reg_addr_t ra1_i,
    input  reg_addr_t ra2_i,
    input  reg_addr_t ra3_i,
    input  reg_addr_t ra4_i,
    output word_t     rd1_o,
    output word_t     rd2_o,
    output word_t     rd3_o,
    output word_t     rd4_o,
    input  logic      we1_i,
    input  reg_addr_t wa1_i,
    input  word_t     wd1_i,
    input  logic      we2_i,
    input  reg_addr_t wa2_i,
    input  word_t     wd2_i
);
    word_t regs [2**`REG_AW];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 2**`REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we1_i) begin
                regs[wa1_i] <= wd1_i;
            end
            // slave is younger, its write lands last
            if (we2_i) begin
                regs[wa2_i] <= wd2_i;
            end
        end
    end

    assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];
    assign rd3_o = (ra3_i == '0) ? '0 : regs[ra3_i];
    assign rd4_o = (ra4_i == '0) ? '0 : regs[ra4_i];

endmodule

`default_nettype wire

/* hdl/forward_unit.sv */
`default_nettype none

module forward_unit
    import core_pkg::*;
(
    input  reg_addr_t m_rs_addr_i,
    input  word_t     m_rs_rf_i,
    input  reg_addr_t m_rt_addr_i,
    input  word_t     m_rt_rf_i,
    input  reg_addr_t s_rs_addr_i,
    input  word_t     s_rs_rf_i,
    input  reg_addr_t s_rt_addr_i,
    input  word_t     s_rt_rf_i,
    input  logic      ex_m_wen_i,
    input  reg_addr_t ex_m_waddr_i,
    input  word_t     ex_m_result_i,
    input  logic      ex_s_wen_i,
    input  reg_addr_t ex_s_waddr_i,
    input  word_t     ex_s_result_i,
    input  logic      wb_m_wen_i,
    input  reg_addr_t wb_m_waddr_i,
    input  word_t     wb_m_result_i,
    input  logic      wb_s_wen_i,
    input  reg_addr_t wb_s_waddr_i,
    input  word_t     wb_s_result_i,
    output word_t     m_rs_o,
    output word_t     m_rt_o,
    output word_t     s_rs_o,
    output word_t     s_rt_o
);
    // newest producer first, slave before master within a stage
    function automatic word_t pick(input reg_addr_t addr, input word_t rf_val);
        if (addr == '0) begin
            pick = rf_val;
        end else if (ex_s_wen_i && (ex_s_waddr_i == addr)) begin
            pick = ex_s_result_i;
        end else if (ex_m_wen_i && (ex_m_waddr_i == addr)) begin
            pick = ex_m_result_i;
        end else if (wb_s_wen_i && (wb_s_waddr_i == addr)) begin
            pick = wb_s_result_i;
        end else if (wb_m_wen_i && (wb_m_waddr_i == addr)) begin
            pick = wb_m_result_i;
        end else begin
            pick = rf_val;
        end
    endfunction

    always_comb begin
        m_rs_o = pick(m_rs_addr_i, m_rs_rf_i);
        m_rt_o = pick(m_rt_addr_i, m_rt_rf_i);
        s_rs_o = pick(s_rs_addr_i, s_rs_rf_i);
        s_rt_o = pick(s_rt_addr_i, s_rt_rf_i);
    end

endmodule

`default_nettype wire

/* hdl/alu.sv */
`default_nettype none

module alu
    import core_pkg::*;
(
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   y_o
);
    always_comb begin
        case (op_i)
            ALU_ADD: y_o = a_i + b_i;
            ALU_SUB: y_o = a_i - b_i;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_XOR: y_o = a_i ^ b_i;
            // signed compare, result in bit 0
            ALU_SLT: y_o = word_t'($signed(a_i) < $signed(b_i));
            // b holds the zero-extended immediate
            ALU_LUI: y_o = b_i << 16;
            default: y_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/dual_issue_core.sv */
`default_nettype none
`include "core_defines.svh"

module dual_issue_core
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      inst_ok1_i,
    input  logic      inst_ok2_i,
    input  inst_t     inst_rdata1_i,
    input  inst_t     inst_rdata2_i,
    output logic      fetch_en_o,
    output logic      wb_master_valid_o,
    output word_t     wb_master_pc_o,
    output reg_addr_t wb_master_waddr_o,
    output word_t     wb_master_wdata_o,
    output logic      wb_slave_valid_o,
    output word_t     wb_slave_pc_o,
    output reg_addr_t wb_slave_waddr_o,
    output word_t     wb_slave_wdata_o
);
    localparam int CW = $clog2(`FIFO_DEPTH) + 1;

    inst_t         m_inst, s_inst;
    word_t         m_pc, s_pc;
    logic [CW-1:0] fifo_count;
    logic          m_issue, s_issue;

    // decode stage
    reg_addr_t     m_rs, m_rt, m_waddr, s_rs, s_rt, s_waddr;
    word_t         m_imm, s_imm;
    alu_op_e       m_op, s_op;
    logic          m_use_imm, s_use_imm, m_wen, s_wen;
    word_t         m_rs_rf, m_rt_rf, s_rs_rf, s_rt_rf;
    word_t         m_rs_val, m_rt_val, s_rs_val, s_rt_val;

    // execute stage
    logic          e_m_valid, e_s_valid, e_m_wen, e_s_wen;
    reg_addr_t     e_m_waddr, e_s_waddr;
    alu_op_e       e_m_op, e_s_op;
    word_t         e_m_pc, e_s_pc, e_m_a, e_m_b, e_s_a, e_s_b, e_m_res, e_s_res;

    // writeback stage
    logic          w_m_valid, w_s_valid, w_m_wen, w_s_wen;
    reg_addr_t     w_m_waddr, w_s_waddr;
    word_t         w_m_pc, w_s_pc, w_m_res, w_s_res;

    logic          ex_m_we, ex_s_we, wb_m_we, wb_s_we;

    assign ex_m_we = e_m_valid & e_m_wen;
    assign ex_s_we = e_s_valid & e_s_wen;
    assign wb_m_we = w_m_valid & w_m_wen;
    assign wb_s_we = w_s_valid & w_s_wen;

    // words offered while fetch_en_o is low are dropped
    inst_fifo u_inst_fifo (
        .clk         (clk),
        .rst_i       (rst_i),
        .wr1_en_i    (inst_ok1_i & fetch_en_o),
        .wr2_en_i    (inst_ok2_i & fetch_en_o),
        .wr1_data_i  (inst_rdata1_i),
        .wr2_data_i  (inst_rdata2_i),
        .pop1_i      (m_issue),
        .pop2_i      (s_issue),
        .head_inst_o (m_inst),
        .head_pc_o   (m_pc),
        .next_inst_o (s_inst),
        .next_pc_o   (s_pc),
        .count_o     (fifo_count),
        .room_o      (fetch_en_o)
    );

    decoder u_decoder_master (
        .inst_i    (m_inst),
        .rs_o      (m_rs),
        .rt_o      (m_rt),
        .waddr_o   (m_waddr),
        .imm_o     (m_imm),
        .alu_op_o  (m_op),
        .use_imm_o (m_use_imm),
        .reg_wen_o (m_wen)
    );

    decoder u_decoder_slave (
        .inst_i    (s_inst),
        .rs_o      (s_rs),
        .rt_o      (s_rt),
        .waddr_o   (s_waddr),
        .imm_o     (s_imm),
        .alu_op_o  (s_op),
        .use_imm_o (s_use_imm),
        .reg_wen_o (s_wen)
    );

    issue_ctrl u_issue_ctrl (
        .count_i        (fifo_count),
        .master_wen_i   (m_wen),
        .master_waddr_i (m_waddr),
        .slave_rs_i     (s_rs),
        .slave_rt_i     (s_rt),
        .master_issue_o (m_issue),
        .slave_issue_o  (s_issue)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst_i (rst_i),
        .ra1_i (m_rs),  .rd1_o (m_rs_rf),
        .ra2_i (m_rt),  .rd2_o (m_rt_rf),
        .ra3_i (s_rs),  .rd3_o (s_rs_rf),
        .ra4_i (s_rt),  .rd4_o (s_rt_rf),
        .we1_i (wb_m_we), .wa1_i (w_m_waddr), .wd1_i (w_m_res),
        .we2_i (wb_s_we), .wa2_i (w_s_waddr), .wd2_i (w_s_res)
    );

    forward_unit u_forward_unit (
        .m_rs_addr_i   (m_rs),    .m_rs_rf_i (m_rs_rf),
        .m_rt_addr_i   (m_rt),    .m_rt_rf_i (m_rt_rf),
        .s_rs_addr_i   (s_rs),    .s_rs_rf_i (s_rs_rf),
        .s_rt_addr_i   (s_rt),    .s_rt_rf_i (s_rt_rf),
        .ex_m_wen_i    (ex_m_we), .ex_m_waddr_i (e_m_waddr), .ex_m_result_i (e_m_res),
        .ex_s_wen_i    (ex_s_we), .ex_s_waddr_i (e_s_waddr), .ex_s_result_i (e_s_res),
        .wb_m_wen_i    (wb_m_we), .wb_m_waddr_i (w_m_waddr), .wb_m_result_i (w_m_res),
        .wb_s_wen_i    (wb_s_we), .wb_s_waddr_i (w_s_waddr), .wb_s_result_i (w_s_res),
        .m_rs_o        (m_rs_val),
        .m_rt_o        (m_rt_val),
        .s_rs_o        (s_rs_val),
        .s_rt_o        (s_rt_val)
    );

    alu u_alu_master (.op_i (e_m_op), .a_i (e_m_a), .b_i (e_m_b), .y_o (e_m_res));
    alu u_alu_slave  (.op_i (e_s_op), .a_i (e_s_a), .b_i (e_s_b), .y_o (e_s_res));

    // a lane that does not issue carries a bubble forward
    always_ff @(posedge clk) begin
        if (rst_i) begin
            e_m_valid <= 1'b0;
            e_s_valid <= 1'b0;
            e_m_wen   <= 1'b0;
            e_s_wen   <= 1'b0;
            w_m_valid <= 1'b0;
            w_s_valid <= 1'b0;
            w_m_wen   <= 1'b0;
            w_s_wen   <= 1'b0;
        end else begin
            e_m_valid <= m_issue;
            e_s_valid <= s_issue;
            e_m_wen   <= m_issue & m_wen;
            e_s_wen   <= s_issue & s_wen;
            w_m_valid <= e_m_valid;
            w_s_valid <= e_s_valid;
            w_m_wen   <= ex_m_we;
            w_s_wen   <= ex_s_we;
        end
    end

    always_ff @(posedge clk) begin
        e_m_pc    <= m_pc;
        e_m_op    <= m_op;
        e_m_waddr <= m_waddr;
        e_m_a     <= m_rs_val;
        e_m_b     <= m_use_imm ? m_imm : m_rt_val;
        e_s_pc    <= s_pc;
        e_s_op    <= s_op;
        e_s_waddr <= s_waddr;
        e_s_a     <= s_rs_val;
        e_s_b     <= s_use_imm ? s_imm : s_rt_val;
        w_m_pc    <= e_m_pc;
        w_m_waddr <= e_m_waddr;
        w_m_res   <= e_m_res;
        w_s_pc    <= e_s_pc;
        w_s_waddr <= e_s_waddr;
        w_s_res   <= e_s_res;
    end

    // retirement ports mirror the register file writes
    assign wb_master_valid_o = wb_m_we;
    assign wb_master_pc_o    = w_m_pc;
    assign wb_master_waddr_o = w_m_waddr;
    assign wb_master_wdata_o = w_m_res;
    assign wb_slave_valid_o  = wb_s_we;
    assign wb_slave_pc_o     = w_s_pc;
    assign wb_slave_waddr_o  = w_s_waddr;
    assign wb_slave_wdata_o  = w_s_res;

endmodule

`default_nettype wire

/* test/clk_gen.sv */
`default_nettype none

module clk_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // held over three rising edges, released between edges
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* test/core_properties.sv */
`default_nettype none

module core_properties
    import core_pkg::*;
(
    input logic      clk_i,
    input logic      rst_i,
    input logic      fetch_en_i,
    input logic      m_valid_i,
    input reg_addr_t m_waddr_i,
    input word_t     m_pc_i,
    input logic      s_valid_i,
    input reg_addr_t s_waddr_i,
    input word_t     s_pc_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // writeback valids come from flops cleared by reset
    reset_quiet: assert property (@(posedge clk_i) $past(rst_i) |-> !m_valid_i && !s_valid_i)
        else $error("writeback valid while reset is applied");

    // slave lands last in the register file, so it has to be the younger one
    same_dest_order: assert property (@(posedge clk_i) disable iff (rst_i)
        (m_valid_i && s_valid_i && (m_waddr_i == s_waddr_i)) |-> (s_pc_i == m_pc_i + 32'd4))
        else $error("slave shares the master destination but is not the younger one");

    // buffer is empty after reset
    fetch_after_reset: assert property (@(posedge clk_i) $fell(rst_i) |-> fetch_en_i)
        else $error("fetch enable low in the first cycle after reset");

endmodule

`default_nettype wire

/* test/tb_core.sv */
`default_nettype none
`include "core_defines.svh"

module tb_core
    import core_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;

    logic      clk;
    logic      rst;
    logic      inst_ok1;
    logic      inst_ok2;
    inst_t     inst_rdata1;
    inst_t     inst_rdata2;
    logic      fetch_en;
    logic      wb_m_valid;
    word_t     wb_m_pc;
    reg_addr_t wb_m_waddr;
    word_t     wb_m_wdata;
    logic      wb_s_valid;
    word_t     wb_s_pc;
    reg_addr_t wb_s_waddr;
    word_t     wb_s_wdata;

    // reference model and expected retirements in program order
    word_t     model_regs [32];
    word_t     model_pc;
    word_t     exp_pc_q[$];
    reg_addr_t exp_reg_q[$];
    word_t     exp_data_q[$];
    inst_t     prog_q[$];

    integer    seed;
    int        errors;
    int        test_errors;
    int        tests_run;
    int        tests_failed;
    int        both_cycles;
    int        fetch_low_cycles;

    clk_gen u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    dual_issue_core u_dut (
        .clk               (clk),
        .rst_i             (rst),
        .inst_ok1_i        (inst_ok1),
        .inst_ok2_i        (inst_ok2),
        .inst_rdata1_i     (inst_rdata1),
        .inst_rdata2_i     (inst_rdata2),
        .fetch_en_o        (fetch_en),
        .wb_master_valid_o (wb_m_valid),
        .wb_master_pc_o    (wb_m_pc),
        .wb_master_waddr_o (wb_m_waddr),
        .wb_master_wdata_o (wb_m_wdata),
        .wb_slave_valid_o  (wb_s_valid),
        .wb_slave_pc_o     (wb_s_pc),
        .wb_slave_waddr_o  (wb_s_waddr),
        .wb_slave_wdata_o  (wb_s_wdata)
    );

    bind dual_issue_core core_properties u_core_properties (
        .clk_i      (clk),
        .rst_i      (rst_i),
        .fetch_en_i (fetch_en_o),
        .m_valid_i  (wb_master_valid_o),
        .m_waddr_i  (wb_master_waddr_o),
        .m_pc_i     (wb_master_pc_o),
        .s_valid_i  (wb_slave_valid_o),
        .s_waddr_i  (wb_slave_waddr_o),
        .s_pc_i     (wb_slave_pc_o)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic note_failure(input string what);
        errors++;
        test_errors++;
        $display("%s", what);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input reg_addr_t got, input reg_addr_t exp, input string what);
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("error at %0t ns: %s is r%0d, expected r%0d", $time, what, got, exp);
        end
    endtask

    task automatic match_retirement(input word_t pc, input reg_addr_t waddr, input word_t data,
                                    input string lane);
        word_t     exp_pc;
        reg_addr_t exp_reg;
        word_t     exp_data;
        if (exp_pc_q.size() == 0) begin
            note_failure($sformatf("%s lane retired pc %h although nothing was expected",
                                   lane, pc));
        end else begin
            exp_pc   = exp_pc_q.pop_front();
            exp_reg  = exp_reg_q.pop_front();
            exp_data = exp_data_q.pop_front();
            check_word(pc, exp_pc, {lane, " pc"});
            check_reg(waddr, exp_reg, {lane, " register"});
            check_word(data, exp_data, {lane, " data"});
        end
    endtask

    task automatic sample_wb();
        if (wb_m_valid && wb_s_valid) begin
            both_cycles++;
        end
        // master is the older of a pair
        if (wb_m_valid) begin
            match_retirement(wb_m_pc, wb_m_waddr, wb_m_wdata, "master");
        end
        if (wb_s_valid) begin
            match_retirement(wb_s_pc, wb_s_waddr, wb_s_wdata, "slave");
        end
    endtask

    // outputs are stable at the falling edge, inputs change right after
    task automatic step();
        @(negedge clk);
        sample_wb();
    endtask

    function automatic inst_t r_type(input logic [5:0] fn, input reg_addr_t rd,
                                     input reg_addr_t rs, input reg_addr_t rt);
        return {`OP_SPECIAL, rs, rt, rd, 5'b00000, fn};
    endfunction

    function automatic inst_t i_type(input logic [5:0] op, input reg_addr_t rt,
                                     input reg_addr_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic predict(input inst_t inst);
        logic [5:0] op;
        logic [5:0] fn;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  dest;
        word_t      a;
        word_t      b;
        word_t      sext;
        word_t      zext;
        word_t      res;
        bit         writes;
        op     = inst[31:26];
        fn     = inst[5:0];
        rs     = inst[25:21];
        rt     = inst[20:16];
        a      = model_regs[rs];
        b      = model_regs[rt];
        sext   = {{16{inst[15]}}, inst[15:0]};
        zext   = {16'h0000, inst[15:0]};
        dest   = rt;
        writes = 1'b1;
        res    = '0;
        case (op)
            `OP_SPECIAL: begin
                dest = inst[15:11];
                case (fn)
                    `FN_ADDU: res = a + b;
                    `FN_SUBU: res = a - b;
                    `FN_AND:  res = a & b;
                    `FN_OR:   res = a | b;
                    `FN_XOR:  res = a ^ b;
                    `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:  writes = 1'b0;
                endcase
            end
            `OP_ADDIU: res = a + sext;
            `OP_ANDI:  res = a & zext;
            `OP_ORI:   res = a | zext;
            `OP_LUI:   res = {inst[15:0], 16'h0000};
            default:   writes = 1'b0;
        endcase
        // $0 stays zero, such writes never show on the wb ports
        if (writes && (dest != 5'd0)) begin
            model_regs[dest] = res;
            exp_pc_q.push_back(model_pc);
            exp_reg_q.push_back(dest);
            exp_data_q.push_back(res);
        end
        model_pc = model_pc + 32'd4;
    endtask

    task automatic feed_program(input bit two_per_beat);
        int stall;
        stall = 0;
        while (prog_q.size() > 0) begin
            step();
            inst_ok1 = 1'b0;
            inst_ok2 = 1'b0;
            if (fetch_en) begin
                stall       = 0;
                inst_rdata1 = prog_q.pop_front();
                inst_ok1    = 1'b1;
                predict(inst_rdata1);
                if (two_per_beat && (prog_q.size() > 0)) begin
                    inst_rdata2 = prog_q.pop_front();
                    inst_ok2    = 1'b1;
                    predict(inst_rdata2);
                end
            end else begin
                fetch_low_cycles++;
                stall++;
                if (stall > TIMEOUT) begin
                    abort_run("fetch enable stayed low, the core stopped issuing");
                end
            end
        end
        step();
        inst_ok1 = 1'b0;
        inst_ok2 = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_pc_q.size() > 0) begin
            step();
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("expected retirements never arrived");
            end
        end
    endtask

    task automatic open_test();
        test_errors      = 0;
        both_cycles      = 0;
        fetch_low_cycles = 0;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("%s: %s, %0d mismatches", name, (test_errors == 0) ? "pass" : "fail",
                 test_errors);
    endtask

    task automatic reset_state();
        int waited;
        open_test();
        waited = 0;
        step();
        while (rst) begin
            step();
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("reset was never released");
            end
        end
        repeat (4) begin
            step();
            if (!fetch_en) begin
                note_failure("fetch enable is low although the buffer is empty");
            end
        end
        close_test("reset_state");
    endtask

    task automatic independent_stream();
        open_test();
        for (int k = 1; k <= 12; k++) begin
            if (k % 3 == 0) begin
                prog_q.push_back(i_type(`OP_LUI, reg_addr_t'(k), 5'd0, 16'(k * 32'h1111)));
            end else begin
                prog_q.push_back(i_type(`OP_ORI, reg_addr_t'(k), 5'd0, 16'(32'h0f0f ^ k)));
            end
        end
        feed_program(1'b0);
        wait_drain();
        close_test("independent_stream");
    endtask

    task automatic forwarding_chain();
        logic [5:0] fn;
        open_test();
        prog_q.push_back(i_type(`OP_ORI, 5'd8, 5'd0, 16'h1357));
        // each step reads the result just before it
        for (int k = 0; k < 12; k++) begin
            case (k % 4)
                0:       fn = `FN_ADDU;
                1:       fn = `FN_SUBU;
                2:       fn = `FN_XOR;
                default: fn = `FN_SLT;
            endcase
            prog_q.push_back(r_type(fn, reg_addr_t'(9 + k), reg_addr_t'(8 + k),
                                    reg_addr_t'(7 + k)));
        end
        feed_program(1'b1);
        wait_drain();
        if (both_cycles != 0) begin
            note_failure("both lanes retired together inside a fully dependent chain");
        end
        close_test("forwarding_chain");
    endtask

    task automatic dual_issue_pairs();
        open_test();
        for (int k = 0; k < 8; k++) begin
            prog_q.push_back(i_type(`OP_ORI, reg_addr_t'(16 + 2 * k), 5'd0,
                                    16'(32'h2200 + k)));
            prog_q.push_back(i_type(`OP_ADDIU, reg_addr_t'(17 + 2 * k), 5'd1,
                                    16'(32'hff00 + k)));
        end
        feed_program(1'b1);
        wait_drain();
        if (both_cycles == 0) begin
            note_failure("independent pairs never retired in the same cycle");
        end
        close_test("dual_issue_pairs");
    endtask

    task automatic back_pressure();
        open_test();
        for (int k = 0; k < 24; k++) begin
            if (k % 2 == 0) begin
                prog_q.push_back(i_type(`OP_ADDIU, 5'd3, 5'd3, 16'(32'h8001 + k * 37)));
            end else begin
                prog_q.push_back(r_type(`FN_XOR, 5'd3, 5'd3, 5'd17));
            end
        end
        feed_program(1'b1);
        wait_drain();
        if (fetch_low_cycles == 0) begin
            note_failure("fetch enable never dropped while a dependent chain was fed");
        end
        close_test("back_pressure");
    endtask

    task automatic random_program();
        logic [31:0] r;
        logic [31:0] r2;
        int          sel;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        inst_t       inst;
        open_test();
        for (int k = 0; k < 200; k++) begin
            r   = $random(seed);
            r2  = $random(seed);
            sel = r[7:0] % 11;
            // sixteen registers keep dependences frequent
            rs  = {1'b0, r[11:8]};
            rt  = {1'b0, r[15:12]};
            rd  = {1'b0, r[19:16]};
            case (sel)
                0:       inst = r_type(`FN_ADDU, rd, rs, rt);
                1:       inst = r_type(`FN_SUBU, rd, rs, rt);
                2:       inst = r_type(`FN_AND, rd, rs, rt);
                3:       inst = r_type(`FN_OR, rd, rs, rt);
                4:       inst = r_type(`FN_XOR, rd, rs, rt);
                5:       inst = r_type(`FN_SLT, rd, rs, rt);
                6:       inst = i_type(`OP_ADDIU, rt, rs, r2[15:0]);
                7:       inst = i_type(`OP_ANDI, rt, rs, r2[15:0]);
                8:       inst = i_type(`OP_ORI, rt, rs, r2[15:0]);
                9:       inst = i_type(`OP_LUI, rt, rs, r2[15:0]);
                default: inst = r[20] ? r_type(6'h00, rd, rs, rt) : {6'h3f, r2[25:0]};
            endcase
            prog_q.push_back(inst);
        end
        feed_program(1'b1);
        wait_drain();
        close_test("random_program");
    endtask

    initial begin
        seed         = 65949;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_pc     = `RESET_PC;
        inst_ok1     = 1'b0;
        inst_ok2     = 1'b0;
        inst_rdata1  = '0;
        inst_rdata2  = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        reset_state();
        independent_stream();
        forwarding_chain();
        dual_issue_pairs();
        back_pressure();
        random_program();
        // trailing no-ops leave the buffer and the two stages
        repeat (`FIFO_DEPTH + 2) step();
        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
hdl/core_pkg.sv
hdl/inst_fifo.sv
hdl/decoder.sv
hdl/issue_ctrl.sv
hdl/regfile.sv
hdl/forward_unit.sv
hdl/alu.sv
hdl/dual_issue_core.sv
test/clk_gen.sv
test/core_properties.sv
test/tb_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_core -f compile.f -o tb_core_sim

result=$(./obj_dir/tb_core_sim || true)
echo "$result"
echo "$result" | grep -qx "Test OK"
